// ==== design/wb_consts.svh ====
`ifndef WB_CONSTS_SVH
`define WB_CONSTS_SVH

// Opcode bits [6:2], the low two bits are always 2'b11
`define OPC_ARI_RTYPE_5 5'b01100
`define OPC_ARI_ITYPE_5 5'b00100
`define OPC_LOAD_5      5'b00000
`define OPC_STORE_5     5'b01000
`define OPC_BRANCH_5    5'b11000
`define OPC_JAL_5       5'b11011
`define OPC_JALR_5      5'b11001
`define OPC_LUI_5       5'b01101
`define OPC_AUIPC_5     5'b00101

// Arithmetic funct3 with an alternate form
`define FNC_ADD_SUB     3'b000
`define FNC_SLL         3'b001
`define FNC_SRL_SRA     3'b101

// Instruction bit 30, set for SUB and SRA
`define FNC2_ALT        1'b1

// Load width and sign
`define FNC_LB          3'b000
`define FNC_LH          3'b001
`define FNC_LW          3'b010
`define FNC_LBU         3'b100
`define FNC_LHU         3'b101

// Writeback source
`define WB_ALU          2'b00
`define WB_MEM          2'b01
`define WB_PC4          2'b10
`define WDATA_DONT_CARE 2'b11

// Load data source
`define DOUT_DMEM       1'b0
`define DOUT_UART       1'b1

`define RF_DEPTH        32

`endif

// ==== design/wb_pkg.sv ====
`default_nettype none

package wb_pkg;

    // Data word: pc, ALU result, address, load data, register contents
    typedef logic [31:0] word_t;

    // Raw instruction word
    typedef logic [31:0] inst_t;

    // Architectural register index
    typedef logic [4:0] reg_idx_t;

    // Writeback source code
    typedef logic [1:0] wb_sel_t;

    // Load source, data memory or UART
    typedef logic dout_sel_t;

    // Load width and sign field
    typedef logic [2:0] funct3_t;

endpackage

`default_nettype wire

// ==== design/wb_control.sv ====
`default_nettype none

`include "wb_consts.svh"

module wb_control (
    input  wb_pkg::inst_t     inst,
    input  wb_pkg::word_t     addr,
    output wb_pkg::wb_sel_t   wbsel,
    output wb_pkg::dout_sel_t dsel,
    output logic              regwen
);

    import wb_pkg::*;

    logic [4:0] opcode5;
    funct3_t    funct3;
    logic       alt_bit;

    assign opcode5 = inst[6:2];
    assign funct3  = inst[14:12];
    assign alt_bit = inst[30];

    always_comb begin
        wbsel  = `WDATA_DONT_CARE;
        dsel   = `DOUT_DMEM;
        regwen = 1'b0;

        case (opcode5)
            `OPC_ARI_RTYPE_5: begin
                wbsel = `WB_ALU;
                // Only ADD/SUB and SRL/SRA have a form with bit 30 set
                if (alt_bit != `FNC2_ALT ||
                    funct3 == `FNC_ADD_SUB ||
                    funct3 == `FNC_SRL_SRA) begin
                    regwen = 1'b1;
                end
            end

            `OPC_ARI_ITYPE_5: begin
                wbsel = `WB_ALU;
                // Bit 30 is immediate except on shifts, SLLI has no alternate
                if (!(funct3 == `FNC_SLL && alt_bit == `FNC2_ALT)) begin
                    regwen = 1'b1;
                end
            end

            `OPC_LOAD_5: begin
                case (funct3)
                    `FNC_LB, `FNC_LH, `FNC_LW, `FNC_LBU, `FNC_LHU: begin
                        wbsel  = `WB_MEM;
                        regwen = 1'b1;
                        // UART is mapped in the upper half of the address space
                        dsel   = addr[31] ? `DOUT_UART : `DOUT_DMEM;
                    end
                    default: begin
                        regwen = 1'b0;
                    end
                endcase
            end

            `OPC_STORE_5, `OPC_BRANCH_5: begin
                // No destination register
                regwen = 1'b0;
            end

            `OPC_JAL_5, `OPC_JALR_5: begin
                wbsel  = `WB_PC4;
                regwen = 1'b1;
            end

            `OPC_LUI_5, `OPC_AUIPC_5: begin
                // Immediate already formed by the ALU
                wbsel  = `WB_ALU;
                regwen = 1'b1;
            end

            default: begin
                regwen = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/wb_retire_buf.sv ====
`default_nettype none

module wb_retire_buf (
    input  logic          clk,
    input  logic          rst,
    input  logic          in_valid,
    output logic          in_ready,
    input  wb_pkg::inst_t in_inst,
    input  wb_pkg::word_t in_pc,
    input  wb_pkg::word_t in_alu,
    input  wb_pkg::word_t in_addr,
    input  wb_pkg::word_t in_dmem_dout,
    input  wb_pkg::word_t in_uart_dout,
    output logic          out_valid,
    input  logic          out_ready,
    output wb_pkg::inst_t out_inst,
    output wb_pkg::word_t out_pc,
    output wb_pkg::word_t out_alu,
    output wb_pkg::word_t out_addr,
    output wb_pkg::word_t out_dmem_dout,
    output wb_pkg::word_t out_uart_dout
);

    import wb_pkg::*;

    inst_t inst_q      [0:1];
    word_t pc_q        [0:1];
    word_t alu_q       [0:1];
    word_t addr_q      [0:1];
    word_t dmem_dout_q [0:1];
    word_t uart_dout_q [0:1];

    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       push;
    logic       pop;

    // A full buffer still takes a record when the head leaves on the same edge
    assign in_ready  = (count != 2'd2) || out_ready;
    assign out_valid = (count != 2'd0);
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            inst_q[wr_ptr]      <= in_inst;
            pc_q[wr_ptr]        <= in_pc;
            alu_q[wr_ptr]       <= in_alu;
            addr_q[wr_ptr]      <= in_addr;
            dmem_dout_q[wr_ptr] <= in_dmem_dout;
            uart_dout_q[wr_ptr] <= in_uart_dout;
        end
    end

    assign out_inst      = inst_q[rd_ptr];
    assign out_pc        = pc_q[rd_ptr];
    assign out_alu       = alu_q[rd_ptr];
    assign out_addr      = addr_q[rd_ptr];
    assign out_dmem_dout = dmem_dout_q[rd_ptr];
    assign out_uart_dout = uart_dout_q[rd_ptr];

endmodule

`default_nettype wire

// ==== design/wb_data_select.sv ====
`default_nettype none

`include "wb_consts.svh"

module wb_data_select (
    input  wb_pkg::wb_sel_t   wbsel,
    input  wb_pkg::dout_sel_t dsel,
    input  wb_pkg::funct3_t   funct3,
    input  wb_pkg::word_t     addr,
    input  wb_pkg::word_t     pc,
    input  wb_pkg::word_t     alu,
    input  wb_pkg::word_t     dmem_dout,
    input  wb_pkg::word_t     uart_dout,
    output wb_pkg::word_t     wb_data
);

    import wb_pkg::*;

    word_t raw_word;
    word_t shifted;
    word_t load_val;

    assign raw_word = (dsel == `DOUT_UART) ? uart_dout : dmem_dout;

    // Move the addressed byte lane down to bit 0
    assign shifted = raw_word >> {addr[1:0], 3'b000};

    always_comb begin
        case (funct3)
            `FNC_LB:  load_val = {{24{shifted[7]}}, shifted[7:0]};
            `FNC_LH:  load_val = {{16{shifted[15]}}, shifted[15:0]};
            `FNC_LW:  load_val = shifted;
            `FNC_LBU: load_val = {24'd0, shifted[7:0]};
            `FNC_LHU: load_val = {16'd0, shifted[15:0]};
            default:  load_val = shifted;
        endcase
    end

    always_comb begin
        case (wbsel)
            `WB_ALU: wb_data = alu;
            `WB_MEM: wb_data = load_val;
            // Link address for jumps
            `WB_PC4: wb_data = pc + 32'd4;
            default: wb_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
`default_nettype none

`include "wb_consts.svh"

module reg_file (
    input  logic             clk,
    input  logic             rst,
    input  logic             wen,
    input  wb_pkg::reg_idx_t waddr,
    input  wb_pkg::word_t    wdata,
    input  wb_pkg::reg_idx_t raddr_a,
    output wb_pkg::word_t    rdata_a,
    input  wb_pkg::reg_idx_t raddr_b,
    output wb_pkg::word_t    rdata_b
);

    import wb_pkg::*;

    word_t regs [0:`RF_DEPTH-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RF_DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads as zero regardless of contents
    assign rdata_a = (raddr_a == 5'd0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == 5'd0) ? '0 : regs[raddr_b];

endmodule

`default_nettype wire

// ==== design/wb_stage.sv ====
`default_nettype none

module wb_stage (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    output logic             in_ready,
    input  wb_pkg::inst_t    in_inst,
    input  wb_pkg::word_t    in_pc,
    input  wb_pkg::word_t    in_alu,
    input  wb_pkg::word_t    in_addr,
    input  wb_pkg::word_t    in_dmem_dout,
    input  wb_pkg::word_t    in_uart_dout,
    output logic             commit_valid,
    input  logic             commit_ready,
    output wb_pkg::word_t    commit_pc,
    output wb_pkg::reg_idx_t commit_rd,
    output logic             commit_wen,
    output wb_pkg::word_t    commit_data,
    input  wb_pkg::reg_idx_t rd_addr_a,
    output wb_pkg::word_t    rd_data_a,
    input  wb_pkg::reg_idx_t rd_addr_b,
    output wb_pkg::word_t    rd_data_b
);

    import wb_pkg::*;

    inst_t     head_inst;
    word_t     head_alu;
    word_t     head_addr;
    word_t     head_dmem_dout;
    word_t     head_uart_dout;
    wb_sel_t   wbsel;
    dout_sel_t dsel;
    logic      regwen;
    word_t     wb_data;
    logic      rf_wen;

    wb_retire_buf u_retire_buf (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_inst       (in_inst),
        .in_pc         (in_pc),
        .in_alu        (in_alu),
        .in_addr       (in_addr),
        .in_dmem_dout  (in_dmem_dout),
        .in_uart_dout  (in_uart_dout),
        .out_valid     (commit_valid),
        .out_ready     (commit_ready),
        .out_inst      (head_inst),
        .out_pc        (commit_pc),
        .out_alu       (head_alu),
        .out_addr      (head_addr),
        .out_dmem_dout (head_dmem_dout),
        .out_uart_dout (head_uart_dout)
    );

    // Decode and select act on the head record only
    wb_control u_control (
        .inst   (head_inst),
        .addr   (head_addr),
        .wbsel  (wbsel),
        .dsel   (dsel),
        .regwen (regwen)
    );

    wb_data_select u_data_select (
        .wbsel     (wbsel),
        .dsel      (dsel),
        .funct3    (head_inst[14:12]),
        .addr      (head_addr),
        .pc        (commit_pc),
        .alu       (head_alu),
        .dmem_dout (head_dmem_dout),
        .uart_dout (head_uart_dout),
        .wb_data   (wb_data)
    );

    assign commit_rd   = head_inst[11:7];
    assign commit_wen  = regwen;
    assign commit_data = regwen ? wb_data : '0;

    // Register file updates on the commit handshake
    assign rf_wen = commit_valid && commit_ready && commit_wen;

    reg_file u_reg_file (
        .clk     (clk),
        .rst     (rst),
        .wen     (rf_wen),
        .waddr   (commit_rd),
        .wdata   (commit_data),
        .raddr_a (rd_addr_a),
        .rdata_a (rd_data_a),
        .raddr_b (rd_addr_b),
        .rdata_b (rd_data_b)
    );

endmodule

`default_nettype wire

// ==== dv/wb_stage_chk.sv ====
`default_nettype none

module wb_stage_chk (
    input logic             clk,
    input logic             rst,
    input logic             in_valid,
    input logic             in_ready,
    input logic             commit_valid,
    input logic             commit_ready,
    input wb_pkg::word_t    commit_pc,
    input wb_pkg::reg_idx_t commit_rd,
    input logic             commit_wen,
    input wb_pkg::word_t    commit_data,
    input wb_pkg::word_t    rd_data_a,
    input wb_pkg::word_t    rd_data_b
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [1:0] occupancy;
    int         assert_fails = 0;

    // Records held, tracked from the two handshakes
    always_ff @(posedge clk) begin
        if (rst) begin
            occupancy <= 2'd0;
        end else begin
            occupancy <= occupancy + {1'b0, in_valid && in_ready}
                                   - {1'b0, commit_valid && commit_ready};
        end
    end

    ready_with_space: assert property (@(posedge clk) disable iff (rst)
        (occupancy != 2'd2) |-> in_ready)
    else begin
        assert_fails++;
        $error("in_ready low while the retire buffer has space");
    end

    // Head record holds under back-pressure
    commit_hold: assert property (@(posedge clk) disable iff (rst)
        (commit_valid && !commit_ready) |=> (commit_valid && $stable(commit_pc) &&
            $stable(commit_rd) && $stable(commit_wen) && $stable(commit_data)))
    else begin
        assert_fails++;
        $error("commit fields changed while stalled");
    end

    data_gated: assert property (@(posedge clk) disable iff (rst)
        (commit_valid && !commit_wen) |-> (commit_data == '0))
    else begin
        assert_fails++;
        $error("commit_data nonzero with commit_wen low");
    end

    outputs_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown({in_ready, commit_valid, rd_data_a, rd_data_b}))
    else begin
        assert_fails++;
        $error("unknown value on a handshake or read port output");
    end

    commit_known: assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> !$isunknown({commit_pc, commit_rd, commit_wen, commit_data}))
    else begin
        assert_fails++;
        $error("unknown value on a commit field");
    end

endmodule

bind wb_stage wb_stage_chk u_chk (.*);

`default_nettype wire

// ==== dv/wb_stage_tb.sv ====
`default_nettype none

`include "wb_consts.svh"

module wb_stage_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import wb_pkg::*;

    typedef struct packed {
        inst_t inst;
        word_t pc;
        word_t alu;
        word_t addr;
        word_t dmem;
        word_t uart;
    } rec_t;

    localparam int MODE_ALU     = 0;
    localparam int MODE_LOAD    = 1;
    localparam int MODE_NOWRITE = 2;
    localparam int MODE_MIXED   = 3;

    localparam int N_ALU      = 40;
    localparam int N_LOAD     = 60;
    localparam int N_NOWRITE  = 40;
    localparam int N_BP       = 60;
    localparam int N_MIXED    = 80;
    localparam int TOTAL_RECS = N_ALU + N_LOAD + N_NOWRITE + N_BP + N_MIXED;
    // Six cycles per record at the heaviest stall rate, plus reset and reads
    localparam int PLANNED_CYCLES = 8 + 6 * TOTAL_RECS + 4 * 64;
    localparam int WATCHDOG_NS    = 2 * PLANNED_CYCLES * 8;

    logic     clk;
    logic     rst;
    logic     in_valid;
    logic     in_ready;
    inst_t    in_inst;
    word_t    in_pc;
    word_t    in_alu;
    word_t    in_addr;
    word_t    in_dmem_dout;
    word_t    in_uart_dout;
    logic     commit_valid;
    logic     commit_ready;
    word_t    commit_pc;
    reg_idx_t commit_rd;
    logic     commit_wen;
    word_t    commit_data;
    reg_idx_t rd_addr_a;
    word_t    rd_data_a;
    reg_idx_t rd_addr_b;
    word_t    rd_data_b;

    rec_t        model_q [$];
    word_t       model_regs [0:`RF_DEPTH-1];
    word_t       pc_next;
    string       cur_test = "reset";
    int          test_errs = 0;
    int          error_count = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    wb_stage UUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: simulation still running after %0d ns", WATCHDOG_NS);
        $display("Errors found");
        $finish;
    end

    task automatic check_val(input string what, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("FAIL %s %s: expected %h, actual %h", cur_test, what, expected, actual);
            test_errs++;
            error_count++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errs != 0) begin
            tests_failed++;
        end
        $display("Test %s: %s (%0d mismatches)", cur_test, (test_errs == 0) ? "ok" : "FAILED",
                 test_errs);
    endtask

    // Random instruction of one class with funct3 and bit 30 kept legal
    function automatic inst_t make_inst(input int cls, input reg_idx_t rd);
        inst_t      w;
        logic [4:0] opc;
        w = $urandom();
        case (cls)
            0: begin
                opc = `OPC_ARI_RTYPE_5;
                if (w[14:12] != `FNC_ADD_SUB && w[14:12] != `FNC_SRL_SRA) begin
                    w[30] = 1'b0;
                end
            end
            1: begin
                opc = `OPC_ARI_ITYPE_5;
                if (w[14:12] == `FNC_SLL) begin
                    w[30] = 1'b0;
                end
            end
            2: opc = `OPC_LUI_5;
            3: opc = `OPC_AUIPC_5;
            4: opc = `OPC_JAL_5;
            5: opc = `OPC_JALR_5;
            6: begin
                opc = `OPC_LOAD_5;
                case ($urandom_range(4))
                    0:       w[14:12] = `FNC_LB;
                    1:       w[14:12] = `FNC_LH;
                    2:       w[14:12] = `FNC_LW;
                    3:       w[14:12] = `FNC_LBU;
                    default: w[14:12] = `FNC_LHU;
                endcase
            end
            7: opc = `OPC_STORE_5;
            8: opc = `OPC_BRANCH_5;
            default: begin
                // MISC-MEM, SYSTEM, LOAD-FP, AMO
                case ($urandom_range(3))
                    0:       opc = 5'b00011;
                    1:       opc = 5'b11100;
                    2:       opc = 5'b00001;
                    default: opc = 5'b01011;
                endcase
            end
        endcase
        w[6:0]  = {opc, 2'b11};
        w[11:7] = rd;
        return w;
    endfunction

    function automatic rec_t next_record(input int mode);
        rec_t     r;
        int       cls;
        reg_idx_t rd;
        case (mode)
            MODE_ALU:  cls = $urandom_range(5);
            MODE_LOAD: cls = 6;
            default:   cls = $urandom_range(9);
        endcase
        rd = 5'($urandom_range(31));
        // Writing classes aimed at x0
        if (mode == MODE_NOWRITE && cls <= 6) begin
            rd = 5'd0;
        end
        r.inst  = make_inst(cls, rd);
        r.pc    = pc_next;
        pc_next = pc_next + 32'd4;
        r.alu   = $urandom();
        r.addr  = $urandom();
        r.dmem  = $urandom();
        r.uart  = $urandom();
        return r;
    endfunction

    function automatic void expect_commit(input rec_t r, output logic wen, output word_t data);
        word_t lane;
        wen  = 1'b0;
        data = '0;
        // Addressed byte lane of the chosen load source moved to bit 0
        lane = (r.addr[31] ? r.uart : r.dmem) >> (8 * r.addr[1:0]);
        case (r.inst[6:2])
            `OPC_ARI_RTYPE_5, `OPC_ARI_ITYPE_5, `OPC_LUI_5, `OPC_AUIPC_5: begin
                wen  = 1'b1;
                data = r.alu;
            end
            `OPC_JAL_5, `OPC_JALR_5: begin
                wen  = 1'b1;
                data = r.pc + 32'd4;
            end
            `OPC_LOAD_5: begin
                wen = 1'b1;
                case (r.inst[14:12])
                    `FNC_LB:  data = 32'($signed(lane[7:0]));
                    `FNC_LH:  data = 32'($signed(lane[15:0]));
                    `FNC_LBU: data = 32'(lane[7:0]);
                    `FNC_LHU: data = 32'(lane[15:0]);
                    default:  data = lane;
                endcase
            end
            default: wen = 1'b0;
        endcase
    endfunction

    // Reference model updated on every handshake
    always @(posedge clk) begin : monitor
        rec_t  head;
        logic  exp_wen;
        word_t exp_data;
        if (!rst) begin
            if (model_q.size() < 2) begin
                check_val("in_ready", 32'd1, 32'(in_ready));
            end else if (!commit_ready) begin
                check_val("in_ready", 32'd0, 32'(in_ready));
            end
            check_val("commit_valid", 32'(model_q.size() != 0), 32'(commit_valid));
            if (commit_valid && commit_ready && model_q.size() != 0) begin
                head = model_q.pop_front();
                expect_commit(head, exp_wen, exp_data);
                check_val("commit_pc", head.pc, commit_pc);
                check_val("commit_rd", 32'(head.inst[11:7]), 32'(commit_rd));
                check_val("commit_wen", 32'(exp_wen), 32'(commit_wen));
                check_val("commit_data", exp_wen ? exp_data : 32'd0, commit_data);
                if (exp_wen && head.inst[11:7] != 5'd0) begin
                    model_regs[head.inst[11:7]] = exp_data;
                end
            end
            if (in_valid && in_ready) begin
                model_q.push_back({in_inst, in_pc, in_alu, in_addr, in_dmem_dout, in_uart_dout});
            end
        end
    end

    task automatic read_pair(input reg_idx_t a, input reg_idx_t b);
        @(posedge clk);
        #1;
        rd_addr_a = a;
        rd_addr_b = b;
        #1;
        check_val($sformatf("rd_data_a x%0d", a), model_regs[a], rd_data_a);
        check_val($sformatf("rd_data_b x%0d", b), model_regs[b], rd_data_b);
    endtask

    task automatic compare_reads(input int n);
        for (int i = 0; i < n; i++) begin
            read_pair(5'($urandom_range(31)), 5'($urandom_range(31)));
        end
    endtask

    task automatic sweep_regs();
        for (int i = 0; i < `RF_DEPTH; i++) begin
            read_pair(5'(i), 5'(`RF_DEPTH - 1 - i));
        end
    endtask

    // Sends n records with random gaps and commit_ready low in stall_pct percent of cycles
    task automatic run_traffic(input int n, input int mode, input int stall_pct);
        int   sent;
        logic hs;
        sent = 0;
        while (sent < n || model_q.size() != 0) begin
            @(posedge clk);
            hs = in_valid && in_ready;
            #1;
            if (hs) begin
                sent++;
                in_valid = 1'b0;
            end
            if (sent < n && !in_valid && $urandom_range(3) != 0) begin
                {in_inst, in_pc, in_alu, in_addr, in_dmem_dout, in_uart_dout} = next_record(mode);
                in_valid = 1'b1;
            end
            commit_ready = ($urandom_range(99) >= stall_pct);
        end
        in_valid     = 1'b0;
        commit_ready = 1'b0;
    endtask

    initial begin
        void'($urandom(14));
        rst          = 1'b1;
        in_valid     = 1'b0;
        {in_inst, in_pc, in_alu, in_addr, in_dmem_dout, in_uart_dout} = '0;
        commit_ready = 1'b0;
        rd_addr_a    = '0;
        rd_addr_b    = '0;
        pc_next      = 32'h0000_1000;
        for (int i = 0; i < `RF_DEPTH; i++) begin
            model_regs[i] = '0;
        end
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        start_test("reset");
        check_val("commit_valid", 32'd0, 32'(commit_valid));
        check_val("in_ready", 32'd1, 32'(in_ready));
        compare_reads(8);
        end_test();

        start_test("alu_and_jump");
        run_traffic(N_ALU, MODE_ALU, 20);
        compare_reads(16);
        end_test();

        start_test("loads");
        run_traffic(N_LOAD, MODE_LOAD, 20);
        compare_reads(8);
        end_test();

        start_test("no_write");
        run_traffic(N_NOWRITE, MODE_NOWRITE, 20);
        sweep_regs();
        end_test();

        start_test("back_pressure");
        run_traffic(N_BP, MODE_MIXED, 60);
        end_test();

        start_test("register_sweep");
        run_traffic(N_MIXED, MODE_MIXED, 30);
        sweep_regs();
        end_test();

        $display("Summary: %0d tests, %0d failed, %0d mismatches, %0d assertion failures",
                 tests_run, tests_failed, error_count, UUT.u_chk.assert_fails);
        if (error_count == 0 && UUT.u_chk.assert_fails == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+design
design/wb_pkg.sv
design/wb_control.sv
design/wb_retire_buf.sv
design/wb_data_select.sv
design/reg_file.sv
design/wb_stage.sv
dv/wb_stage_chk.sv
dv/wb_stage_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := wb_stage_tb
FILELIST   := build.f
COMMON     := --timing --assert --timescale 1ns/1ps --top-module $(TOP)
LINT_FLAGS := --lint-only $(COMMON)
SIM_FLAGS  := --binary $(COMMON)
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
